/* logic/stq_pkg.sv */
package stq_pkg;

  // ======================================================================
  // Widths and types
  // ======================================================================
  localparam int ADDR_W = 32;
  localparam int DATA_W = 64;  // One 8-byte lane
  localparam int STRB_W = 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;

  typedef enum logic [1:0] {
    SIZE_B,
    SIZE_H,
    SIZE_W,
    SIZE_D
  } size_t;

  // Entry life cycle, always advancing in this order
  typedef enum logic [1:0] {
    STQ_FREE,
    STQ_WAIT_EXEC,
    STQ_EXEC_DONE,
    STQ_COMMITTED
  } stq_state_t;

  // Bytes of the lane touched by an aligned access
  function automatic strb_t gen_strb(input size_t size, input logic [2:0] offset);
    strb_t base;
    case (size)
      SIZE_B:  base = strb_t'(8'h01);
      SIZE_H:  base = strb_t'(8'h03);
      SIZE_W:  base = strb_t'(8'h0f);
      default: base = strb_t'(8'hff);
    endcase
    return base << offset;
  endfunction

endpackage

/* logic/stq_entry_array.sv */
`timescale 1ns/1ps

module stq_entry_array
  import stq_pkg::*;
#(
  parameter int STQ_DEPTH = 8,
  localparam int IDX_W = $clog2(STQ_DEPTH),
  localparam int PTR_W = IDX_W + 1
) (
  input  logic              i_clk,
  input  logic              i_reset_n,
  // Allocation
  input  logic              i_alloc_valid,
  output logic              o_alloc_ready,
  output logic [PTR_W-1:0]  o_alloc_idx,
  // Execution update
  input  logic              i_exec_valid,
  input  logic [PTR_W-1:0]  i_exec_idx,
  input  addr_t             i_exec_addr,
  input  size_t             i_exec_size,
  input  data_t             i_exec_data,
  // Commit and pop
  input  logic              i_commit_valid,
  input  logic              i_pop,
  // Entry view for forwarding
  output logic [STQ_DEPTH-1:0] o_ent_valid_exec,
  output addr_t             o_ent_addr [STQ_DEPTH],
  output size_t             o_ent_size [STQ_DEPTH],
  output data_t             o_ent_data [STQ_DEPTH],
  output logic [PTR_W-1:0]  o_head_ptr,
  // Head entry for drain
  output addr_t             o_head_addr,
  output size_t             o_head_size,
  output data_t             o_head_data,
  output logic              o_head_committed
);

  stq_state_t        r_state [STQ_DEPTH];
  addr_t             r_addr  [STQ_DEPTH];
  size_t             r_size  [STQ_DEPTH];
  data_t             r_data  [STQ_DEPTH];

  logic [PTR_W-1:0]  r_head_ptr;
  logic [PTR_W-1:0]  r_cmt_ptr;
  logic [PTR_W-1:0]  r_tail_ptr;

  logic [IDX_W-1:0]  w_head_idx;
  logic [IDX_W-1:0]  w_cmt_idx;
  logic [IDX_W-1:0]  w_tail_idx;
  logic [IDX_W-1:0]  w_exec_entry;
  logic              w_full;
  logic              w_alloc_fire;
  logic              w_exec_we;

  assign w_head_idx   = r_head_ptr[IDX_W-1:0];
  assign w_cmt_idx    = r_cmt_ptr[IDX_W-1:0];
  assign w_tail_idx   = r_tail_ptr[IDX_W-1:0];
  assign w_exec_entry = i_exec_idx[IDX_W-1:0];

  // Same index, opposite wrap
  assign w_full = (r_tail_ptr[IDX_W] != r_head_ptr[IDX_W]) && (w_tail_idx == w_head_idx);

  assign o_alloc_ready = !w_full;
  assign o_alloc_idx   = r_tail_ptr;
  assign w_alloc_fire  = i_alloc_valid && !w_full;
  assign w_exec_we     = i_exec_valid && (r_state[w_exec_entry] == STQ_WAIT_EXEC);

  // ======================================================================
  // Pointers and entry states
  // ======================================================================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head_ptr <= '0;
      r_cmt_ptr  <= '0;
      r_tail_ptr <= '0;
      for (int e = 0; e < STQ_DEPTH; e++) begin
        r_state[e] <= STQ_FREE;
      end
    end else begin
      // Targets are in distinct states, never the same entry
      if (w_alloc_fire) begin
        r_state[w_tail_idx] <= STQ_WAIT_EXEC;
        r_tail_ptr          <= r_tail_ptr + 1'b1;
      end
      if (w_exec_we) begin
        r_state[w_exec_entry] <= STQ_EXEC_DONE;
      end
      if (i_commit_valid) begin
        r_state[w_cmt_idx] <= STQ_COMMITTED;
        r_cmt_ptr          <= r_cmt_ptr + 1'b1;
      end
      if (i_pop) begin
        r_state[w_head_idx] <= STQ_FREE;
        r_head_ptr          <= r_head_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_exec_we) begin
      r_addr[w_exec_entry] <= i_exec_addr;
      r_size[w_exec_entry] <= i_exec_size;
      r_data[w_exec_entry] <= i_exec_data;
    end
  end

  for (genvar e = 0; e < STQ_DEPTH; e++) begin : g_ent
    assign o_ent_valid_exec[e] = (r_state[e] == STQ_EXEC_DONE) ||
                                 (r_state[e] == STQ_COMMITTED);
    assign o_ent_addr[e] = r_addr[e];
    assign o_ent_size[e] = r_size[e];
    assign o_ent_data[e] = r_data[e];
  end

  assign o_head_ptr       = r_head_ptr;
  assign o_head_addr      = r_addr[w_head_idx];
  assign o_head_size      = r_size[w_head_idx];
  assign o_head_data      = r_data[w_head_idx];
  assign o_head_committed = (r_state[w_head_idx] == STQ_COMMITTED);

  // ======================================================================
  // Protocol checks against the pipe, ROB and drain side
  // ======================================================================
  a_exec_target: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_exec_valid |-> r_state[w_exec_entry] == STQ_WAIT_EXEC)
    else $error("Execution update to entry not waiting for execution");

  a_commit_executed: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_commit_valid |-> r_state[w_cmt_idx] == STQ_EXEC_DONE)
    else $error("Commit of a store that has not executed");

  a_pop_committed: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_pop |-> r_state[w_head_idx] == STQ_COMMITTED)
    else $error("Pop of an uncommitted head entry");

endmodule

/* logic/stq_fwd_unit.sv */
`timescale 1ns/1ps

module stq_fwd_unit
  import stq_pkg::*;
#(
  parameter int STQ_DEPTH = 8,
  localparam int IDX_W = $clog2(STQ_DEPTH),
  localparam int PTR_W = IDX_W + 1
) (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  logic                 i_fwd_valid,
  input  addr_t                i_fwd_addr,
  input  size_t                i_fwd_size,
  input  logic [PTR_W-1:0]     i_fwd_tail,   // Tail seen at load dispatch
  input  logic [PTR_W-1:0]     i_head_ptr,
  input  logic [STQ_DEPTH-1:0] i_ent_valid_exec,
  input  addr_t                i_ent_addr [STQ_DEPTH],
  input  size_t                i_ent_size [STQ_DEPTH],
  input  data_t                i_ent_data [STQ_DEPTH],
  output logic                 o_fwd_valid,
  output strb_t                o_fwd_strb,
  output data_t                o_fwd_data
);

  strb_t                w_req_strb;
  logic [PTR_W-1:0]     w_win_len;
  logic                 w_win_ok;
  logic [STQ_DEPTH-1:0] w_match;
  strb_t                w_ent_strb [STQ_DEPTH];
  data_t                w_ent_data_al [STQ_DEPTH];
  strb_t                w_fwd_strb;
  data_t                w_fwd_data;

  logic                 r_fwd_valid;
  strb_t                r_fwd_strb;
  data_t                r_fwd_data;

  assign w_req_strb = gen_strb(i_fwd_size, i_fwd_addr[2:0]);
  assign w_win_len  = i_fwd_tail - i_head_ptr;
  assign w_win_ok   = (w_win_len <= PTR_W'(STQ_DEPTH));  // Head not past the snapshot

  for (genvar e = 0; e < STQ_DEPTH; e++) begin : g_match
    logic [IDX_W-1:0] w_age;  // Distance from head

    assign w_age            = IDX_W'(e) - i_head_ptr[IDX_W-1:0];
    assign w_ent_strb[e]    = gen_strb(i_ent_size[e], i_ent_addr[e][2:0]);
    assign w_ent_data_al[e] = i_ent_data[e] << {i_ent_addr[e][2:0], 3'b000};
    assign w_match[e] = i_ent_valid_exec[e] && w_win_ok &&
                        ({1'b0, w_age} < w_win_len) &&
                        (i_ent_addr[e][ADDR_W-1:3] == i_fwd_addr[ADDR_W-1:3]) &&
                        |(w_ent_strb[e] & w_req_strb);
  end

  // Walk from head toward the load; younger hits overwrite older ones
  always_comb begin
    logic [IDX_W-1:0] v_idx;
    w_fwd_strb = '0;
    w_fwd_data = '0;
    for (int k = 0; k < STQ_DEPTH; k++) begin
      v_idx = i_head_ptr[IDX_W-1:0] + IDX_W'(k);
      for (int b = 0; b < STRB_W; b++) begin
        if (w_match[v_idx] && w_ent_strb[v_idx][b] && w_req_strb[b]) begin
          w_fwd_strb[b]       = 1'b1;
          w_fwd_data[b*8 +: 8] = w_ent_data_al[v_idx][b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_fwd_valid <= 1'b0;
      r_fwd_strb  <= '0;
    end else begin
      r_fwd_valid <= i_fwd_valid && |w_fwd_strb;
      r_fwd_strb  <= i_fwd_valid ? w_fwd_strb : '0;
    end
  end

  always_ff @(posedge i_clk) begin
    r_fwd_data <= w_fwd_data;
  end

  assign o_fwd_valid = r_fwd_valid;
  assign o_fwd_strb  = r_fwd_strb;
  assign o_fwd_data  = r_fwd_data;

  a_strb_in_req: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_fwd_valid |=> (o_fwd_strb & ~$past(w_req_strb)) == '0)
    else $error("Forwarded bytes outside the load request");

endmodule

/* logic/stq_drain.sv */
`timescale 1ns/1ps

module stq_drain
  import stq_pkg::*;
(
  input  logic   i_clk,
  input  logic   i_reset_n,
  // Head entry
  input  logic   i_head_committed,
  input  addr_t  i_head_addr,
  input  size_t  i_head_size,
  input  data_t  i_head_data,
  // Store buffer write channel
  output logic   o_sb_valid,
  output addr_t  o_sb_addr,
  output strb_t  o_sb_strb,
  output data_t  o_sb_data,
  input  logic   i_sb_ready,
  output logic   o_pop
);

  logic [2:0] w_offset;
  strb_t      w_strb;
  data_t      w_shifted;
  data_t      w_byte_mask;

  assign w_offset  = i_head_addr[2:0];
  assign w_strb    = gen_strb(i_head_size, w_offset);
  assign w_shifted = i_head_data << {w_offset, 3'b000};

  for (genvar b = 0; b < STRB_W; b++) begin : g_mask
    assign w_byte_mask[b*8 +: 8] = {8{w_strb[b]}};
  end

  // Beat is the head itself, so it stays put until the pop
  assign o_sb_valid = i_head_committed;
  assign o_sb_addr  = {i_head_addr[ADDR_W-1:3], 3'b000};
  assign o_sb_strb  = w_strb;
  assign o_sb_data  = w_shifted & w_byte_mask;  // Unused bytes zero
  assign o_pop      = o_sb_valid && i_sb_ready;

  // ======================================================================
  // Stalled beat must not change
  // ======================================================================
  property p_hold_beat;
    @(posedge i_clk) disable iff (!i_reset_n)
      o_sb_valid && !i_sb_ready |=> o_sb_valid && $stable(o_sb_addr) &&
                                    $stable(o_sb_strb) && $stable(o_sb_data);
  endproperty

  a_hold_beat: assert property (p_hold_beat)
    else $error("Store buffer beat changed while stalled");

endmodule

/* logic/stq_top.sv */
`timescale 1ns/1ps

module stq_top
  import stq_pkg::*;
#(
  parameter int STQ_DEPTH = 8,
  localparam int PTR_W = $clog2(STQ_DEPTH) + 1
) (
  input  logic              i_clk,
  input  logic              i_reset_n,
  // Dispatch
  input  logic              i_alloc_valid,
  output logic              o_alloc_ready,
  output logic [PTR_W-1:0]  o_alloc_idx,
  // Execution pipe
  input  logic              i_exec_valid,
  input  logic [PTR_W-1:0]  i_exec_idx,
  input  addr_t             i_exec_addr,
  input  size_t             i_exec_size,
  input  data_t             i_exec_data,
  // ROB
  input  logic              i_commit_valid,
  // Load pipe
  input  logic              i_fwd_valid,
  input  addr_t             i_fwd_addr,
  input  size_t             i_fwd_size,
  input  logic [PTR_W-1:0]  i_fwd_tail,
  output logic              o_fwd_valid,
  output strb_t             o_fwd_strb,
  output data_t             o_fwd_data,
  // Store buffer
  output logic              o_sb_valid,
  output addr_t             o_sb_addr,
  output strb_t             o_sb_strb,
  output data_t             o_sb_data,
  input  logic              i_sb_ready
);

  logic [STQ_DEPTH-1:0] w_ent_valid_exec;
  addr_t                w_ent_addr [STQ_DEPTH];
  size_t                w_ent_size [STQ_DEPTH];
  data_t                w_ent_data [STQ_DEPTH];
  logic [PTR_W-1:0]     w_head_ptr;
  addr_t                w_head_addr;
  size_t                w_head_size;
  data_t                w_head_data;
  logic                 w_head_committed;
  logic                 w_pop;

  stq_entry_array #(.STQ_DEPTH(STQ_DEPTH)) u_entry_array (
    .i_clk(i_clk), .i_reset_n(i_reset_n),
    .i_alloc_valid(i_alloc_valid), .o_alloc_ready(o_alloc_ready), .o_alloc_idx(o_alloc_idx),
    .i_exec_valid(i_exec_valid), .i_exec_idx(i_exec_idx), .i_exec_addr(i_exec_addr),
    .i_exec_size(i_exec_size), .i_exec_data(i_exec_data),
    .i_commit_valid(i_commit_valid), .i_pop(w_pop),
    .o_ent_valid_exec(w_ent_valid_exec), .o_ent_addr(w_ent_addr),
    .o_ent_size(w_ent_size), .o_ent_data(w_ent_data), .o_head_ptr(w_head_ptr),
    .o_head_addr(w_head_addr), .o_head_size(w_head_size), .o_head_data(w_head_data),
    .o_head_committed(w_head_committed)
  );

  stq_fwd_unit #(.STQ_DEPTH(STQ_DEPTH)) u_fwd_unit (
    .i_clk(i_clk), .i_reset_n(i_reset_n),
    .i_fwd_valid(i_fwd_valid), .i_fwd_addr(i_fwd_addr), .i_fwd_size(i_fwd_size),
    .i_fwd_tail(i_fwd_tail), .i_head_ptr(w_head_ptr),
    .i_ent_valid_exec(w_ent_valid_exec), .i_ent_addr(w_ent_addr),
    .i_ent_size(w_ent_size), .i_ent_data(w_ent_data),
    .o_fwd_valid(o_fwd_valid), .o_fwd_strb(o_fwd_strb), .o_fwd_data(o_fwd_data)
  );

  stq_drain u_drain (
    .i_clk(i_clk), .i_reset_n(i_reset_n),
    .i_head_committed(w_head_committed), .i_head_addr(w_head_addr),
    .i_head_size(w_head_size), .i_head_data(w_head_data),
    .o_sb_valid(o_sb_valid), .o_sb_addr(o_sb_addr), .o_sb_strb(o_sb_strb),
    .o_sb_data(o_sb_data), .i_sb_ready(i_sb_ready), .o_pop(w_pop)
  );

endmodule

/* test/tb_stq.sv */
`timescale 1ns/1ps

module tb_stq
  import stq_pkg::*;
();

  localparam int STQ_DEPTH   = 8;
  localparam int IDX_W       = 3;
  localparam int PTR_W       = IDX_W + 1;
  localparam int N_STORES    = 40;
  localparam int PLAN_CYCLES = N_STORES * 3 + 60;
  localparam int LIMIT       = 2 * PLAN_CYCLES + 200;

  logic             clk;
  logic             reset_n;
  logic             alloc_valid;
  logic             alloc_ready;
  logic [PTR_W-1:0] alloc_idx;
  logic             exec_valid;
  logic [PTR_W-1:0] exec_idx;
  addr_t            exec_addr;
  size_t            exec_size;
  data_t            exec_data;
  logic             commit_valid;
  logic             fwd_valid_in;
  addr_t            fwd_addr;
  size_t            fwd_size;
  logic [PTR_W-1:0] fwd_tail;
  logic             fwd_valid;
  strb_t            fwd_strb;
  data_t            fwd_data;
  logic             sb_valid;
  addr_t            sb_addr;
  strb_t            sb_strb;
  data_t            sb_data;
  logic             sb_ready;

  // Reference model of the queue
  addr_t            m_addr [STQ_DEPTH];
  size_t            m_size [STQ_DEPTH];
  data_t            m_data [STQ_DEPTH];
  logic             m_exec [STQ_DEPTH];
  logic [PTR_W-1:0] head_ptr = '0;
  logic [PTR_W-1:0] cmt_ptr = '0;
  logic [PTR_W-1:0] tail_ptr = '0;
  addr_t            exp_addr [$];
  strb_t            exp_strb [$];
  data_t            exp_data [$];

  logic [15:0]      lfsr = 16'd35;
  logic             rand_ready = 1'b0;
  logic             held = 1'b0;
  addr_t            hold_addr;
  strb_t            hold_strb;
  data_t            hold_data;
  int               err_beat = 0;
  int               err_fwd = 0;
  int               err_misc = 0;
  int               cycle_cnt = 0;

  stq_top #(.STQ_DEPTH(STQ_DEPTH)) u_dut (
    .i_clk(clk), .i_reset_n(reset_n),
    .i_alloc_valid(alloc_valid), .o_alloc_ready(alloc_ready), .o_alloc_idx(alloc_idx),
    .i_exec_valid(exec_valid), .i_exec_idx(exec_idx), .i_exec_addr(exec_addr),
    .i_exec_size(exec_size), .i_exec_data(exec_data), .i_commit_valid(commit_valid),
    .i_fwd_valid(fwd_valid_in), .i_fwd_addr(fwd_addr), .i_fwd_size(fwd_size),
    .i_fwd_tail(fwd_tail), .o_fwd_valid(fwd_valid), .o_fwd_strb(fwd_strb),
    .o_fwd_data(fwd_data), .o_sb_valid(sb_valid), .o_sb_addr(sb_addr),
    .o_sb_strb(sb_strb), .o_sb_data(sb_data), .i_sb_ready(sb_ready)
  );

  always #4 clk = ~clk;

  // ======================================================================
  // Random source and reference functions
  // ======================================================================
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  function automatic logic [63:0] rnd(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[62:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  // Store data moved to its byte offset, bytes outside the strobe cleared
  function automatic data_t beat_data(input size_t s, input addr_t a, input data_t d);
    strb_t st;
    data_t sh;
    st = gen_strb(s, a[2:0]);
    sh = d << (8 * a[2:0]);
    for (int b = 0; b < STRB_W; b++) begin
      if (!st[b]) sh[b*8 +: 8] = 8'h00;
    end
    return sh;
  endfunction

  // Oldest first, so a younger store overwrites the bytes it covers
  function automatic void fwd_ref(input addr_t a, input size_t s, input logic [PTR_W-1:0] tail,
                                  output strb_t es, output data_t ed);
    strb_t            req;
    strb_t            st;
    data_t            sh;
    logic [PTR_W-1:0] p;
    logic [IDX_W-1:0] e;
    req = gen_strb(s, a[2:0]);
    es  = '0;
    ed  = '0;
    p   = head_ptr;
    while (p != tail) begin
      e  = p[IDX_W-1:0];
      st = gen_strb(m_size[e], m_addr[e][2:0]);
      sh = beat_data(m_size[e], m_addr[e], m_data[e]);
      if (m_exec[e] && m_addr[e][ADDR_W-1:3] == a[ADDR_W-1:3]) begin
        for (int b = 0; b < STRB_W; b++) begin
          if (req[b] && st[b]) begin
            es[b]        = 1'b1;
            ed[b*8 +: 8] = sh[b*8 +: 8];
          end
        end
      end
      p = p + 1'b1;
    end
  endfunction

  // ======================================================================
  // Compare tasks
  // ======================================================================
  task automatic check_beat(input addr_t ea, input strb_t es, input data_t ed);
    if (sb_addr !== ea || sb_strb !== es || sb_data !== ed) begin
      err_beat++;
      $display("ERROR %0t: beat addr %h strb %h data %h, expected %h %h %h",
               $time, sb_addr, sb_strb, sb_data, ea, es, ed);
    end
  endtask

  task automatic check_fwd(input strb_t es, input data_t ed);
    if (fwd_valid !== (es != '0) || fwd_strb !== es || fwd_data !== ed) begin
      err_fwd++;
      $display("ERROR %0t: forward valid %b strb %h data %h, expected %b %h %h",
               $time, fwd_valid, fwd_strb, fwd_data, es != '0, es, ed);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      err_misc++;
      $display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_idx(input logic [PTR_W-1:0] got, input logic [PTR_W-1:0] exp);
    if (got !== exp) begin
      err_misc++;
      $display("ERROR %0t: alloc index %h, expected %h", $time, got, exp);
    end
  endtask

  // ======================================================================
  // Stimulus tasks, each called at a falling edge
  // ======================================================================
  task automatic next_cycle();
    @(negedge clk);
    if (rand_ready) sb_ready = (rnd(1) != 0);
  endtask

  task automatic alloc_store(output logic [PTR_W-1:0] p);
    while (!alloc_ready) next_cycle();
    check_idx(alloc_idx, tail_ptr);
    p           = tail_ptr;
    alloc_valid = 1'b1;
    next_cycle();
    alloc_valid = 1'b0;
    tail_ptr    = tail_ptr + 1'b1;
    m_exec[p[IDX_W-1:0]] = 1'b0;
  endtask

  task automatic exec_store(input logic [PTR_W-1:0] p, input addr_t a, input size_t s,
                            input data_t d);
    exec_valid = 1'b1;
    exec_idx   = p;
    exec_addr  = a;
    exec_size  = s;
    exec_data  = d;
    next_cycle();
    exec_valid = 1'b0;
    m_addr[p[IDX_W-1:0]] = a;
    m_size[p[IDX_W-1:0]] = s;
    m_data[p[IDX_W-1:0]] = d;
    m_exec[p[IDX_W-1:0]] = 1'b1;
  endtask

  task automatic commit_store();
    logic [IDX_W-1:0] e;
    e = cmt_ptr[IDX_W-1:0];
    exp_addr.push_back({m_addr[e][ADDR_W-1:3], 3'b000});
    exp_strb.push_back(gen_strb(m_size[e], m_addr[e][2:0]));
    exp_data.push_back(beat_data(m_size[e], m_addr[e], m_data[e]));
    commit_valid = 1'b1;
    next_cycle();
    commit_valid = 1'b0;
    cmt_ptr      = cmt_ptr + 1'b1;
  endtask

  task automatic send_load(input addr_t a, input size_t s, input logic [PTR_W-1:0] tail);
    strb_t es;
    data_t ed;
    fwd_ref(a, s, tail, es, ed);
    fwd_valid_in = 1'b1;
    fwd_addr     = a;
    fwd_size     = s;
    fwd_tail     = tail;
    next_cycle();
    fwd_valid_in = 1'b0;
    check_fwd(es, ed);
  endtask

  // Beat order, hold while stalled, no lost or extra beats
  always @(posedge clk) begin
    if (held) begin
      check_bit(sb_valid, 1'b1, "stalled beat valid");
      check_beat(hold_addr, hold_strb, hold_data);
    end
    held      = sb_valid && !sb_ready;
    hold_addr = sb_addr;
    hold_strb = sb_strb;
    hold_data = sb_data;
    if (sb_valid && sb_ready) begin
      if (exp_addr.size() == 0) begin
        err_misc++;
        $display("Store buffer accepted a beat with no committed store pending");
      end else begin
        check_beat(exp_addr.pop_front(), exp_strb.pop_front(), exp_data.pop_front());
        head_ptr = head_ptr + 1'b1;
      end
    end
  end

  initial begin : watchdog
    while (cycle_cnt < LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: run did not finish within %0d cycles", LIMIT);
    $display("tests failed");
    $finish;
  end

  initial begin : main
    logic [PTR_W-1:0] idx [8];
    logic [PTR_W-1:0] p;
    addr_t            a;
    addr_t            lane;
    size_t            s;
    clk = 1'b0;
    reset_n = 1'b0;
    alloc_valid = 1'b0;
    exec_valid = 1'b0;
    exec_idx = '0;
    exec_addr = '0;
    exec_size = SIZE_B;
    exec_data = '0;
    commit_valid = 1'b0;
    fwd_valid_in = 1'b0;
    fwd_addr = '0;
    fwd_size = SIZE_B;
    fwd_tail = '0;
    sb_ready = 1'b0;
    repeat (5) @(negedge clk);
    check_bit(sb_valid, 1'b0, "sb valid in reset");
    check_bit(fwd_valid, 1'b0, "fwd valid in reset");
    check_bit(alloc_ready, 1'b1, "alloc ready in reset");
    reset_n = 1'b1;

    // Random store stream under random back-pressure
    rand_ready = 1'b1;
    for (int k = 0; k < N_STORES; k++) begin
      alloc_store(p);
      s = size_t'(rnd(2));
      a = addr_t'(rnd(32)) & ~addr_t'((1 << int'(s)) - 1);
      exec_store(p, a, s, rnd(64));
      commit_store();
    end
    while (exp_addr.size() != 0) next_cycle();
    rand_ready = 1'b0;
    sb_ready   = 1'b0;

    // Fill the queue, then forward from one lane
    for (int k = 0; k < 8; k++) alloc_store(idx[k]);
    check_bit(alloc_ready, 1'b0, "alloc ready with queue full");
    // Lane of the stale store left in the entry that stays unexecuted
    lane = m_addr[idx[4][IDX_W-1:0]] & ~addr_t'(7);
    exec_store(idx[0], lane, SIZE_D, rnd(64));
    exec_store(idx[1], lane | 32'd4, SIZE_W, rnd(64));
    exec_store(idx[2], lane | 32'd2, SIZE_H, rnd(64));
    exec_store(idx[3], lane | 32'd5, SIZE_B, rnd(64));
    exec_store(idx[5], lane + 32'd8, SIZE_D, rnd(64));  // Other lane
    exec_store(idx[6], lane, SIZE_D, rnd(64));          // Younger than the load
    exec_store(idx[7], lane | 32'd1, SIZE_B, rnd(64));
    send_load(lane, SIZE_D, idx[6]);
    send_load(lane, SIZE_D, idx[3]);
    for (int k = 0; k < 5; k++) begin
      s = size_t'(rnd(2));
      send_load(lane | (addr_t'(rnd(3)) & ~addr_t'((1 << int'(s)) - 1)), s, idx[6]);
    end

    // One pop frees a slot
    commit_store();
    sb_ready = 1'b1;
    next_cycle();
    sb_ready = 1'b0;
    check_bit(alloc_ready, 1'b1, "alloc ready after one pop");
    exec_store(idx[4], lane | 32'd6, SIZE_H, rnd(64));
    for (int k = 0; k < 7; k++) commit_store();
    sb_ready = 1'b1;
    while (exp_addr.size() != 0) next_cycle();
    next_cycle();

    $display("Error counts: beat %0d, forward %0d, other %0d", err_beat, err_fwd, err_misc);
    if (err_beat + err_fwd + err_misc == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* flist.f */
logic/stq_pkg.sv
logic/stq_entry_array.sv
logic/stq_fwd_unit.sv
logic/stq_drain.sv
logic/stq_top.sv
test/tb_stq.sv

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of the store queue testbench
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_stq -f flist.f \
  -o tb_stq > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/tb_stq > sim.log 2>&1 || echo "tests failed" >> sim.log
grep -q "tests failed" sim.log && { echo "FAIL, see sim.log"; exit 1; } || { echo "PASS"; exit 0; }
